// ==== logic/core_cfg_pkg.sv ====
// Core configuration package
// Sizes of the integer issue subsystem, shared by queue, register file and lanes

package core_cfg_pkg;

  // Issue queue
  localparam int iq_size      = 8;
  localparam int iq_cnt_width = $clog2(iq_size + 1);

  // Execution lanes and operand ports
  localparam int lane_count = 2;
  localparam int src_count  = 2;
  localparam int rd_ports   = src_count * lane_count;

  // Physical register file
  localparam int prf_size   = 32;
  localparam int tag_width  = 5;
  localparam int data_width = 16;

  // Registers holding a valid value right after reset, tags 0 and up
  localparam int init_regs = 8;

endpackage

// ==== logic/uop_pkg.sv ====
// Micro-op package
// Tags, values, functional units, operations and the structs that carry them

package uop_pkg;

  typedef logic [core_cfg_pkg::tag_width-1:0]  tag_t;
  typedef logic [core_cfg_pkg::data_width-1:0] data_t;

  typedef enum logic [1:0] {
    fu_alu = 2'd0,
    fu_mul = 2'd1
  } fu_t;

  // op_mul is only ever paired with fu_mul
  typedef enum logic [2:0] {
    op_add = 3'd0,
    op_sub = 3'd1,
    op_xor = 3'd2,
    op_mul = 3'd3
  } op_t;

  typedef struct packed {
    tag_t src1;
    tag_t src2;
    tag_t dest;
    fu_t  fu;
    op_t  op;
  } uop_t;

  typedef struct packed {
    tag_t  dest;
    data_t value;
  } result_t;

  // One per lane on the tag broadcast
  typedef struct packed {
    logic valid;
    tag_t tag;
  } wakeup_t;

endpackage

// ==== logic/pipe_reg.sv ====
// Pipeline register stage
// Single valid/ready register with full throughput and a generic payload

`timescale 1ns/10ps

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clock,
  input  logic     reset,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  logic live;
  logic load;

  // Stage starts taking data one cycle after reset is released
  assign in_ready = live & (~out_valid | out_ready);
  assign load     = in_valid & in_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      live      <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      live <= 1'b1;
      if (load) begin
        out_valid <= 1'b1;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (load) begin
      out_data <= in_data;
    end
  end

endmodule

// ==== logic/issue_slot.sv ====
// Issue queue slot
// Holds one micro-op and wakes its two operands from the tag broadcast

`timescale 1ns/10ps

module issue_slot (
  input  logic                                          clock,
  input  logic                                          reset,
  input  logic                                          load,
  input  uop_pkg::uop_t                                 uop_in,
  input  logic                                          src1_ready_in,
  input  logic                                          src2_ready_in,
  input  logic                                          clear,
  input  uop_pkg::wakeup_t [core_cfg_pkg::lane_count-1:0] wakeup,
  output uop_pkg::uop_t                                 uop,
  output logic                                          occupied,
  output logic                                          ready
);

  logic src1_ready;
  logic src2_ready;
  logic src1_hit_in;
  logic src2_hit_in;
  logic src1_hit;
  logic src2_hit;

  // Broadcast matches against the incoming and the held micro-op
  always_comb begin
    src1_hit_in = 1'b0;
    src2_hit_in = 1'b0;
    src1_hit    = 1'b0;
    src2_hit    = 1'b0;
    for (int k = 0; k < core_cfg_pkg::lane_count; k++) begin
      src1_hit_in |= wakeup[k].valid & (wakeup[k].tag == uop_in.src1);
      src2_hit_in |= wakeup[k].valid & (wakeup[k].tag == uop_in.src2);
      src1_hit    |= wakeup[k].valid & (wakeup[k].tag == uop.src1);
      src2_hit    |= wakeup[k].valid & (wakeup[k].tag == uop.src2);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      occupied   <= 1'b0;
      src1_ready <= 1'b0;
      src2_ready <= 1'b0;
    end else if (load) begin
      occupied   <= 1'b1;
      src1_ready <= src1_ready_in | src1_hit_in;
      src2_ready <= src2_ready_in | src2_hit_in;
    end else begin
      if (clear) begin
        occupied <= 1'b0;
      end
      src1_ready <= src1_ready | src1_hit;
      src2_ready <= src2_ready | src2_hit;
    end
  end

  always_ff @(posedge clock) begin
    if (load) begin
      uop <= uop_in;
    end
  end

  assign ready = occupied & src1_ready & src2_ready;

endmodule

// ==== logic/issue_queue.sv ====
// Integer issue queue
// Allocates slots, fans out wakeups and selects micro-ops for the two lanes

`timescale 1ns/10ps

module issue_queue (
  input  logic                                           clock,
  input  logic                                           reset,
  input  logic                                           in_valid,
  output logic                                           in_ready,
  input  uop_pkg::uop_t                                  in_uop,
  output uop_pkg::tag_t    [core_cfg_pkg::src_count-1:0]  sb_tag,
  input  logic             [core_cfg_pkg::src_count-1:0]  sb_ready,
  input  uop_pkg::wakeup_t [core_cfg_pkg::lane_count-1:0] wakeup,
  input  logic             [core_cfg_pkg::lane_count-1:0] lane_ready,
  output logic             [core_cfg_pkg::lane_count-1:0] iss_valid,
  output uop_pkg::uop_t    [core_cfg_pkg::lane_count-1:0] iss_uop
);

  logic [core_cfg_pkg::iq_cnt_width-1:0] free_count;
  logic [core_cfg_pkg::iq_cnt_width-1:0] issue_count;
  logic                                  accept;

  logic [core_cfg_pkg::iq_size-1:0] occupied;
  logic [core_cfg_pkg::iq_size-1:0] ready;
  logic [core_cfg_pkg::iq_size-1:0] is_mul;
  logic [core_cfg_pkg::iq_size-1:0] load;
  logic [core_cfg_pkg::iq_size-1:0] clear;
  logic [core_cfg_pkg::iq_size-1:0] grant0;
  logic [core_cfg_pkg::iq_size-1:0] grant1;

  uop_pkg::uop_t [core_cfg_pkg::iq_size-1:0] slot_uop;

  assign in_ready = (free_count != '0);
  assign accept   = in_valid & in_ready;

  // Scoreboard lookup for the micro-op being loaded
  assign sb_tag[0] = in_uop.src1;
  assign sb_tag[1] = in_uop.src2;

  // Lowest free slot takes the incoming micro-op
  always_comb begin
    logic found;
    found = 1'b0;
    load  = '0;
    for (int j = 0; j < core_cfg_pkg::iq_size; j++) begin
      if (!occupied[j] && !found) begin
        load[j] = accept;
        found   = 1'b1;
      end
    end
  end

  for (genvar j = 0; j < core_cfg_pkg::iq_size; j++) begin : g_slot
    issue_slot issue_slot_inst (
      .clock         (clock),
      .reset         (reset),
      .load          (load[j]),
      .uop_in        (in_uop),
      .src1_ready_in (sb_ready[0]),
      .src2_ready_in (sb_ready[1]),
      .clear         (clear[j]),
      .wakeup        (wakeup),
      .uop           (slot_uop[j]),
      .occupied      (occupied[j]),
      .ready         (ready[j])
    );

    assign is_mul[j] = (slot_uop[j].fu == uop_pkg::fu_mul);
  end

  // Lane 1 prefers a multiply, lane 0 takes ALU work only
  always_comb begin
    logic mul_found;
    logic alu1_found;
    logic alu0_found;
    mul_found  = 1'b0;
    alu1_found = 1'b0;
    alu0_found = 1'b0;
    grant1     = '0;
    grant0     = '0;
    for (int j = 0; j < core_cfg_pkg::iq_size; j++) begin
      if (lane_ready[1] && ready[j] && is_mul[j] && !mul_found) begin
        grant1[j] = 1'b1;
        mul_found = 1'b1;
      end
    end
    for (int j = 0; j < core_cfg_pkg::iq_size; j++) begin
      if (lane_ready[1] && !mul_found && ready[j] && !is_mul[j] && !alu1_found) begin
        grant1[j]  = 1'b1;
        alu1_found = 1'b1;
      end
    end
    for (int j = 0; j < core_cfg_pkg::iq_size; j++) begin
      if (lane_ready[0] && ready[j] && !is_mul[j] && !grant1[j] && !alu0_found) begin
        grant0[j]  = 1'b1;
        alu0_found = 1'b1;
      end
    end
  end

  assign clear        = grant0 | grant1;
  assign iss_valid[0] = |grant0;
  assign iss_valid[1] = |grant1;

  always_comb begin
    iss_uop = '0;
    for (int j = 0; j < core_cfg_pkg::iq_size; j++) begin
      if (grant0[j]) begin
        iss_uop[0] = slot_uop[j];
      end
      if (grant1[j]) begin
        iss_uop[1] = slot_uop[j];
      end
    end
  end

  always_comb begin
    issue_count = '0;
    for (int k = 0; k < core_cfg_pkg::lane_count; k++) begin
      issue_count += core_cfg_pkg::iq_cnt_width'(iss_valid[k]);
    end
  end

  // Slots issued this cycle are free again from the next one
  always_ff @(posedge clock) begin
    if (reset) begin
      free_count <= core_cfg_pkg::iq_cnt_width'(core_cfg_pkg::iq_size);
    end else begin
      free_count <= free_count - core_cfg_pkg::iq_cnt_width'(accept) + issue_count;
    end
  end

endmodule

// ==== logic/phys_regfile.sv ====
// Physical register file
// Register values with a ready bit per tag, four reads and two writes

`timescale 1ns/10ps

module phys_regfile (
  input  logic                                           clock,
  input  logic                                           reset,
  input  uop_pkg::tag_t    [core_cfg_pkg::rd_ports-1:0]   rd_tag,
  output uop_pkg::data_t   [core_cfg_pkg::rd_ports-1:0]   rd_data,
  input  uop_pkg::tag_t    [core_cfg_pkg::src_count-1:0]  sb_tag,
  output logic             [core_cfg_pkg::src_count-1:0]  sb_ready,
  input  uop_pkg::wakeup_t [core_cfg_pkg::lane_count-1:0] wr,
  input  uop_pkg::data_t   [core_cfg_pkg::lane_count-1:0] wr_data
);

  uop_pkg::data_t                   regs [core_cfg_pkg::prf_size];
  logic [core_cfg_pkg::prf_size-1:0] tag_ready;

  always_comb begin
    for (int i = 0; i < core_cfg_pkg::rd_ports; i++) begin
      rd_data[i] = regs[rd_tag[i]];
    end
    for (int i = 0; i < core_cfg_pkg::src_count; i++) begin
      sb_ready[i] = tag_ready[sb_tag[i]];
    end
  end

  // Scoreboard of values already produced
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < core_cfg_pkg::prf_size; i++) begin
        tag_ready[i] <= (i < core_cfg_pkg::init_regs);
      end
    end else begin
      for (int k = 0; k < core_cfg_pkg::lane_count; k++) begin
        if (wr[k].valid) begin
          tag_ready[wr[k].tag] <= 1'b1;
        end
      end
    end
  end

  // Initial architectural values are tag * 257
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < core_cfg_pkg::init_regs; i++) begin
        regs[i] <= uop_pkg::data_t'(i * 257);
      end
    end else begin
      for (int k = 0; k < core_cfg_pkg::lane_count; k++) begin
        if (wr[k].valid) begin
          regs[wr[k].tag] <= wr_data[k];
        end
      end
    end
  end

endmodule

// ==== logic/exec_lane.sv ====
// Integer execution lane
// Issue register, operand read, compute, then writeback and tag broadcast

`timescale 1ns/10ps

module exec_lane #(
  parameter int allow_mul = 1
) (
  input  logic                                          clock,
  input  logic                                          reset,
  input  logic                                          iss_valid,
  input  uop_pkg::uop_t                                 iss_uop,
  output logic                                          lane_ready,
  output uop_pkg::tag_t  [core_cfg_pkg::src_count-1:0]  rd_tag,
  input  uop_pkg::data_t [core_cfg_pkg::src_count-1:0]  rd_data,
  output logic                                          out_valid,
  input  logic                                          out_ready,
  output uop_pkg::result_t                              out_result,
  output uop_pkg::wakeup_t                              wakeup,
  output uop_pkg::data_t                                wr_data
);

  logic           busy;
  uop_pkg::uop_t  uop;
  uop_pkg::data_t product;
  uop_pkg::data_t value;

  // Free, or the held result leaves this cycle
  assign lane_ready = ~busy | out_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= 1'b0;
    end else if (lane_ready) begin
      busy <= iss_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (lane_ready && iss_valid) begin
      uop <= iss_uop;
    end
  end

  assign rd_tag[0] = uop.src1;
  assign rd_tag[1] = uop.src2;

  if (allow_mul != 0) begin : g_mul
    // Low half of the product
    assign product = rd_data[0] * rd_data[1];
  end else begin : g_no_mul
    assign product = '0;
  end

  always_comb begin
    case (uop.op)
      uop_pkg::op_add: value = rd_data[0] + rd_data[1];
      uop_pkg::op_sub: value = rd_data[0] - rd_data[1];
      uop_pkg::op_xor: value = rd_data[0] ^ rd_data[1];
      uop_pkg::op_mul: value = product;
      default:         value = '0;
    endcase
  end

  assign out_valid        = busy;
  assign out_result.dest  = uop.dest;
  assign out_result.value = value;

  // Writeback and broadcast only when the result enters the output stage
  assign wakeup.valid = busy & out_ready;
  assign wakeup.tag   = uop.dest;
  assign wr_data      = value;

endmodule

// ==== logic/int_issue_core.sv ====
// Integer issue core
// Input stage, issue queue, register file, two lanes and their output stages

`timescale 1ns/10ps

module int_issue_core (
  input  logic                                           clock,
  input  logic                                           reset,
  input  logic                                           in_valid,
  output logic                                           in_ready,
  input  uop_pkg::uop_t                                  in_uop,
  output logic             [core_cfg_pkg::lane_count-1:0] res_valid,
  input  logic             [core_cfg_pkg::lane_count-1:0] res_ready,
  output uop_pkg::result_t [core_cfg_pkg::lane_count-1:0] res
);

  logic          q_valid;
  logic          q_ready;
  uop_pkg::uop_t q_uop;

  uop_pkg::tag_t  [core_cfg_pkg::src_count-1:0] sb_tag;
  logic           [core_cfg_pkg::src_count-1:0] sb_ready;
  uop_pkg::tag_t  [core_cfg_pkg::rd_ports-1:0]  rd_tag;
  uop_pkg::data_t [core_cfg_pkg::rd_ports-1:0]  rd_data;

  uop_pkg::wakeup_t [core_cfg_pkg::lane_count-1:0] wakeup;
  uop_pkg::data_t   [core_cfg_pkg::lane_count-1:0] wr_data;
  logic             [core_cfg_pkg::lane_count-1:0] iss_valid;
  logic             [core_cfg_pkg::lane_count-1:0] lane_ready;
  uop_pkg::uop_t    [core_cfg_pkg::lane_count-1:0] iss_uop;
  logic             [core_cfg_pkg::lane_count-1:0] lane_valid;
  logic             [core_cfg_pkg::lane_count-1:0] stage_ready;
  uop_pkg::result_t [core_cfg_pkg::lane_count-1:0] lane_result;

  pipe_reg #(
    .payload_t (uop_pkg::uop_t)
  ) in_stage_inst (
    .clock     (clock),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_uop),
    .out_valid (q_valid),
    .out_ready (q_ready),
    .out_data  (q_uop)
  );

  issue_queue issue_queue_inst (
    .clock      (clock),
    .reset      (reset),
    .in_valid   (q_valid),
    .in_ready   (q_ready),
    .in_uop     (q_uop),
    .sb_tag     (sb_tag),
    .sb_ready   (sb_ready),
    .wakeup     (wakeup),
    .lane_ready (lane_ready),
    .iss_valid  (iss_valid),
    .iss_uop    (iss_uop)
  );

  phys_regfile phys_regfile_inst (
    .clock    (clock),
    .reset    (reset),
    .rd_tag   (rd_tag),
    .rd_data  (rd_data),
    .sb_tag   (sb_tag),
    .sb_ready (sb_ready),
    .wr       (wakeup),
    .wr_data  (wr_data)
  );

  // Lane 1 carries the multiplier
  for (genvar k = 0; k < core_cfg_pkg::lane_count; k++) begin : g_lane
    exec_lane #(
      .allow_mul ((k == 1) ? 1 : 0)
    ) exec_lane_inst (
      .clock      (clock),
      .reset      (reset),
      .iss_valid  (iss_valid[k]),
      .iss_uop    (iss_uop[k]),
      .lane_ready (lane_ready[k]),
      .rd_tag     (rd_tag[k*core_cfg_pkg::src_count +: core_cfg_pkg::src_count]),
      .rd_data    (rd_data[k*core_cfg_pkg::src_count +: core_cfg_pkg::src_count]),
      .out_valid  (lane_valid[k]),
      .out_ready  (stage_ready[k]),
      .out_result (lane_result[k]),
      .wakeup     (wakeup[k]),
      .wr_data    (wr_data[k])
    );

    pipe_reg #(
      .payload_t (uop_pkg::result_t)
    ) out_stage_inst (
      .clock     (clock),
      .reset     (reset),
      .in_valid  (lane_valid[k]),
      .in_ready  (stage_ready[k]),
      .in_data   (lane_result[k]),
      .out_valid (res_valid[k]),
      .out_ready (res_ready[k]),
      .out_data  (res[k])
    );
  end

endmodule

// ==== testbench/tb_result_checker.sv ====
// Result checker for the integer issue core
// Matches results to expected values by destination tag and keeps the counts

`timescale 1ns/10ps

module tb_result_checker (
  input  logic                                            clock,
  input  logic                                            reset,
  input  logic             [core_cfg_pkg::lane_count-1:0] res_valid,
  input  logic             [core_cfg_pkg::lane_count-1:0] res_ready,
  input  uop_pkg::result_t [core_cfg_pkg::lane_count-1:0] res,
  input  logic             [core_cfg_pkg::prf_size-1:0]   exp_live,
  input  logic             [core_cfg_pkg::prf_size-1:0]   exp_lane1,
  input  uop_pkg::data_t   [core_cfg_pkg::prf_size-1:0]   exp_value,
  input  logic                                            test_end,
  input  int                                              test_id,
  input  logic                                            aux_fail,
  input  logic                                            run_end,
  output int                                              seen_count,
  output int                                              error_count
);

  int seen [core_cfg_pkg::prf_size];
  int seen_total   = 0;
  int err_total    = 0;
  int test_errors  = 0;
  int tests_passed = 0;
  int tests_failed = 0;

  function automatic string test_label(input int id);
    case (id)
      1:       return "independent_alu";
      2:       return "dependency_chain";
      3:       return "mixed_mul_alu";
      4:       return "random_backpressure";
      default: return "queue_full";
    endcase
  endfunction

  task automatic count_error();
    test_errors++;
    err_total++;
  endtask

  task automatic check_result(input int lane, input uop_pkg::result_t r);
    seen_total++;
    if (!exp_live[r.dest]) begin
      $display("test %s: result for tag %0d was not expected", test_label(test_id), r.dest);
      count_error();
    end else begin
      seen[r.dest]++;
      if (seen[r.dest] > 1) begin
        $display("test %s: tag %0d came back more than once", test_label(test_id), r.dest);
        count_error();
      end
      if (r.value !== exp_value[r.dest]) begin
        $display("[ERROR] test %s tag %0d: expected %h, actual %h",
                 test_label(test_id), r.dest, exp_value[r.dest], r.value);
        count_error();
      end
      if (exp_lane1[r.dest] && lane != 1) begin
        $display("test %s: multiply result for tag %0d came out of lane %0d",
                 test_label(test_id), r.dest, lane);
        count_error();
      end
    end
  endtask

  task automatic close_test();
    if (aux_fail) begin
      count_error();
    end
    for (int t = 0; t < core_cfg_pkg::prf_size; t++) begin
      if (exp_live[t] && seen[t] == 0) begin
        $display("test %s: no result came back for tag %0d", test_label(test_id), t);
        count_error();
      end
    end
    if (test_errors == 0) begin
      tests_passed++;
      $display("test %0d %s: pass, %0d results", test_id, test_label(test_id), seen_total);
    end else begin
      tests_failed++;
      $display("test %0d %s: fail, %0d errors", test_id, test_label(test_id), test_errors);
    end
  endtask

  // A result moves when valid and ready are both high at the edge
  always @(posedge clock) begin
    if (reset) begin
      for (int t = 0; t < core_cfg_pkg::prf_size; t++) begin
        seen[t] = 0;
      end
      seen_total  = 0;
      test_errors = 0;
    end else begin
      for (int k = 0; k < core_cfg_pkg::lane_count; k++) begin
        if (res_valid[k] && res_ready[k]) begin
          check_result(k, res[k]);
        end
      end
      if (test_end) begin
        close_test();
      end
      if (run_end) begin
        $display("Summary: %0d tests passed, %0d failed, %0d errors",
                 tests_passed, tests_failed, err_total);
      end
    end
    seen_count  <= seen_total;
    error_count <= err_total;
  end

endmodule

// ==== testbench/tb_int_issue_core.sv ====
// Testbench for the integer issue core
// Builds five micro-op sequences, computes the expected values and drives the DUT

`timescale 1ns/10ps

module tb_int_issue_core;

  localparam int test_count      = 5;
  localparam int cycles_per_test = 200;
  localparam int cycle_limit     = test_count * cycles_per_test;
  localparam int reset_cycles    = 3;
  localparam int first_dest      = core_cfg_pkg::init_regs;
  localparam int ps              = core_cfg_pkg::prf_size;
  localparam int lc              = core_cfg_pkg::lane_count;

  // Queue-full test: independent ops, then consumers, then their producer
  localparam int fill_indep    = 6;
  localparam int fill_consumer = 7;

  logic                        clock;
  logic                        reset;
  logic                        in_valid;
  logic                        in_ready;
  uop_pkg::uop_t               in_uop;
  logic             [lc-1:0]   res_valid;
  logic             [lc-1:0]   res_ready;
  uop_pkg::result_t [lc-1:0]   res;

  logic           [ps-1:0] exp_live;
  logic           [ps-1:0] exp_lane1;
  uop_pkg::data_t [ps-1:0] exp_value;
  logic                    test_end;
  int                      test_id;
  logic                    aux_fail;
  logic                    run_end;
  int                      seen_count;
  int                      error_count;

  logic [15:0] stim_lfsr;
  logic [15:0] ready_lfsr;
  // 0 always ready, 1 random, 2 held low
  int          ready_mode;
  int          cycle_count = 0;
  logic        full_seen;

  uop_pkg::uop_t  uop_list[$];
  int             delay_list[$];
  uop_pkg::data_t model_regs [ps];

  int_issue_core int_issue_core_inst (
    .clock     (clock),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_uop    (in_uop),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res       (res)
  );

  tb_result_checker result_checker_inst (
    .clock       (clock),
    .reset       (reset),
    .res_valid   (res_valid),
    .res_ready   (res_ready),
    .res         (res),
    .exp_live    (exp_live),
    .exp_lane1   (exp_lane1),
    .exp_value   (exp_value),
    .test_end    (test_end),
    .test_id     (test_id),
    .aux_fail    (aux_fail),
    .run_end     (run_end),
    .seen_count  (seen_count),
    .error_count (error_count)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    lfsr_next = {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  task automatic draw_bits(input int width, output int value);
    value = 0;
    for (int i = 0; i < width; i++) begin
      stim_lfsr = lfsr_next(stim_lfsr);
      value     = (value << 1) | int'(stim_lfsr[0]);
    end
  endtask

  task automatic pick_tag(input int count, output uop_pkg::tag_t tag);
    int r;
    draw_bits(5, r);
    tag = uop_pkg::tag_t'(r % count);
  endtask

  task automatic pick_op(input logic with_mul, inout uop_pkg::uop_t u);
    int r;
    draw_bits(2, r);
    if (!with_mul) begin
      r = r % 3;
    end
    u.op = uop_pkg::op_t'(3'(r));
    u.fu = (r == 3) ? uop_pkg::fu_mul : uop_pkg::fu_alu;
  endtask

  // Expected value of one micro-op from its operation and operand values
  function automatic uop_pkg::data_t ref_value(input uop_pkg::op_t op,
                                               input uop_pkg::data_t a,
                                               input uop_pkg::data_t b);
    case (op)
      uop_pkg::op_add: ref_value = a + b;
      uop_pkg::op_sub: ref_value = a - b;
      uop_pkg::op_xor: ref_value = a ^ b;
      default:         ref_value = a * b;
    endcase
  endfunction

  task automatic build_test(input int id);
    uop_pkg::uop_t u;
    int            n;
    int            count;
    int            delay;
    uop_list.delete();
    delay_list.delete();
    u = '0;
    n = (id <= 2) ? 16 : (id == 3) ? 20 : (id == 4) ? 24 : fill_indep + fill_consumer + 1;
    for (int i = 0; i < n; i++) begin
      count  = first_dest + i;
      u.dest = uop_pkg::tag_t'(count);
      delay  = 0;
      pick_op(id == 3 || id == 4, u);
      case (id)
        1: begin
          pick_tag(first_dest, u.src1);
          pick_tag(first_dest, u.src2);
          draw_bits(1, delay);
        end
        2: begin
          if (i == 0) begin
            pick_tag(first_dest, u.src1);
          end else begin
            u.src1 = uop_pkg::tag_t'(count - 1);
          end
          pick_tag(count, u.src2);
        end
        3, 4: begin
          pick_tag(count, u.src1);
          pick_tag(count, u.src2);
          draw_bits((id == 3) ? 2 : 1, delay);
        end
        default: begin
          if (i < fill_indep) begin
            pick_tag(first_dest, u.src1);
            pick_tag(first_dest, u.src2);
          end else if (i < n - 1) begin
            // Every consumer waits on the producer that comes last
            u.src1 = uop_pkg::tag_t'(first_dest + n - 1);
            pick_tag(first_dest + fill_indep, u.src2);
          end else begin
            pick_tag(first_dest + fill_indep, u.src1);
            pick_tag(first_dest + fill_indep, u.src2);
          end
        end
      endcase
      uop_list.push_back(u);
      delay_list.push_back(delay);
    end
  endtask

  task automatic compute_expected();
    logic [ps-1:0] known;
    uop_pkg::uop_t u;
    exp_live  = '0;
    exp_lane1 = '0;
    exp_value = '0;
    known     = '0;
    for (int t = 0; t < core_cfg_pkg::init_regs; t++) begin
      model_regs[t] = uop_pkg::data_t'(t * 257);
      known[t]      = 1'b1;
    end
    // Repeated passes, a consumer may be listed before its producer
    for (int pass = 0; pass < uop_list.size(); pass++) begin
      foreach (uop_list[i]) begin
        u = uop_list[i];
        if (!known[u.dest] && known[u.src1] && known[u.src2]) begin
          model_regs[u.dest] = ref_value(u.op, model_regs[u.src1], model_regs[u.src2]);
          known[u.dest]      = 1'b1;
          exp_live[u.dest]   = 1'b1;
          exp_lane1[u.dest]  = (u.fu == uop_pkg::fu_mul);
          exp_value[u.dest]  = model_regs[u.dest];
        end
      end
    end
  endtask

  task automatic apply_reset(output logic failed);
    failed   = 1'b0;
    reset    = 1'b1;
    in_valid = 1'b0;
    repeat (reset_cycles) @(posedge clock);
    #2;
    reset = 1'b0;
    @(posedge clock);
    if (in_ready || res_valid != '0) begin
      $display("in_ready or res_valid was high in the first cycle after reset");
      failed = 1'b1;
    end
    @(posedge clock);
    if (!in_ready) begin
      $display("in_ready did not rise in the second cycle after reset");
      failed = 1'b1;
    end
    #2;
  endtask

  task automatic dispatch_all();
    logic accepted;
    for (int i = 0; i < uop_list.size(); i++) begin
      repeat (delay_list[i]) begin
        @(posedge clock);
        #2;
      end
      in_valid = 1'b1;
      in_uop   = uop_list[i];
      accepted = 1'b0;
      while (!accepted) begin
        @(posedge clock);
        accepted = in_ready;
        if (!in_ready) begin
          full_seen = 1'b1;
        end
        #2;
      end
      in_valid = 1'b0;
    end
  endtask

  // Opens both result ports a few cycles after the dispatch port stalls
  task automatic release_outputs();
    int waited;
    waited = 0;
    while (!full_seen && waited < 60) begin
      @(posedge clock);
      #1;
      waited++;
    end
    repeat (4) @(posedge clock);
    #2;
    ready_mode = 0;
  endtask

  task automatic run_test(input int id);
    logic failed;
    test_id    = id;
    ready_mode = (id == 4) ? 1 : (id == 5) ? 2 : 0;
    build_test(id);
    compute_expected();
    apply_reset(failed);
    full_seen = 1'b0;
    if (id == 5) begin
      fork
        dispatch_all();
        release_outputs();
      join
      if (!full_seen) begin
        $display("test %0d: in_ready never fell while the queue was full", id);
        failed = 1'b1;
      end
    end else begin
      dispatch_all();
    end
    while (seen_count < uop_list.size()) begin
      @(posedge clock);
    end
    // A few more cycles so that a duplicate result would still show
    repeat (4) @(posedge clock);
    #2;
    aux_fail = failed;
    test_end = 1'b1;
    @(posedge clock);
    #2;
    test_end = 1'b0;
    aux_fail = 1'b0;
  endtask

  initial begin : drive_res_ready
    int mode_now;
    forever begin
      @(posedge clock);
      mode_now = ready_mode;
      #2;
      if (mode_now == 1) begin
        for (int k = 0; k < lc; k++) begin
          ready_lfsr   = lfsr_next(ready_lfsr);
          res_ready[k] = ready_lfsr[0];
        end
      end else begin
        res_ready = (mode_now == 0) ? '1 : '0;
      end
    end
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Errors found");
      $finish;
    end
  end

  initial begin
    reset      = 1'b1;
    in_valid   = 1'b0;
    in_uop     = '0;
    res_ready  = '1;
    exp_live   = '0;
    exp_lane1  = '0;
    exp_value  = '0;
    test_end   = 1'b0;
    test_id    = 0;
    aux_fail   = 1'b0;
    run_end    = 1'b0;
    full_seen  = 1'b0;
    ready_mode = 0;
    stim_lfsr  = 16'd56955;
    ready_lfsr = 16'd56955;
    @(posedge clock);
    #2;
    for (int id = 1; id <= test_count; id++) begin
      run_test(id);
    end
    run_end = 1'b1;
    @(posedge clock);
    #2;
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== src.f ====
logic/core_cfg_pkg.sv
logic/uop_pkg.sv
logic/pipe_reg.sv
logic/issue_slot.sv
logic/issue_queue.sv
logic/phys_regfile.sv
logic/exec_lane.sv
logic/int_issue_core.sv
testbench/tb_result_checker.sv
testbench/tb_int_issue_core.sv

// ==== Makefile ====
# Verilator simulation of the integer issue core

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	verilator --binary --timing -f src.f --top-module tb_int_issue_core \
		--Mdir obj_dir -o sim
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir
